// File: dsp_slice_top.f
rtl/dsp_pkg.sv
rtl/dsp_ctrl_regs.sv
rtl/dsp_mult_stage.sv
rtl/dsp_alu.sv
rtl/dsp_pattern_detect.sv
rtl/dsp_slice_top.sv
test/dsp_checker.sv
test/dsp_assert.sv
test/tb_dsp_slice.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DSP slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f dsp_slice_top.f --top-module tb_dsp_slice -o sim_dsp
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dsp 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// File: test/tb_dsp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_slice;
    import dsp_pkg::*;

    logic w_CLK, RSTALLCARRYIN, carryin;
    logic [A_W-1:0] a;
    logic [B_W-1:0] b;
    logic [C_W-1:0] c, p;
    logic [OPMODE_W-1:0] opmode;
    logic [ALUMODE_W-1:0] alumode;
    logic [CARRYINSEL_W-1:0] carryinsel;
    logic pattern_detect, patternb_detect, overflow, underflow;
    int err_count, check_count, tb_errors, err_mark, ovf_seen, unf_seen, n;
    logic [31:0] lfsr_q;

    dsp_slice_top u_dut (.*);
    dsp_checker u_chk (.*);

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int width);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < width; i++) v[i] = lfsr_bit();
        return v;
    endfunction

    function automatic logic [8:0] make_opmode(input logic [1:0] w, input logic [2:0] z,
                                               input logic [1:0] y, input logic [1:0] x);
        return {w, z, y, x};
    endfunction

    // New inputs land on the falling edge
    task automatic drive(input logic [8:0] om, input logic [1:0] am, input logic [2:0] cs,
                         input logic [47:0] cv);
        @(negedge w_CLK);
        opmode     = om;
        alumode    = am;
        carryinsel = cs;
        c          = cv;
        a          = A_W'(rand_bits(A_W));
        b          = B_W'(rand_bits(B_W));
        carryin    = lfsr_bit();
    endtask

    // Idle until the last result of the test has been compared
    task automatic report_test(input string name);
        repeat (4) drive(9'd0, 2'd0, CIN_PIN, '0);
        $display("test %-10s errors %0d", name, err_count + tb_errors - err_mark);
        err_mark = err_count + tb_errors;
    endtask

    initial begin
        w_CLK = 1'b0;
        forever #4 w_CLK = ~w_CLK;
    end

    initial begin
        #100000;
        $display("Simulation stopped at the time limit");
        $display("Verification failed");
        $finish;
    end

    always @(posedge w_CLK) begin
        if (!RSTALLCARRYIN && overflow) ovf_seen++;
        if (!RSTALLCARRYIN && underflow) unf_seen++;
    end

    initial begin
        lfsr_q = 32'hd792cfe4;
        {a, b, c, opmode, alumode, carryinsel, carryin} = '0;
        {tb_errors, err_mark, ovf_seen, unf_seen} = '0;
        RSTALLCARRYIN = 1'b1;
        repeat (4) @(negedge w_CLK);
        RSTALLCARRYIN = 1'b0;
        report_test("reset");

        // Carry select 001 adds no carry, so P is the bare product
        for (int i = 0; i < 40; i++) begin
            drive(make_opmode(W_ZERO, Z_ZERO, Y_M, X_M), 2'd0, 3'b001, '0);
        end
        report_test("multiply");

        for (int i = 0; i < 40; i++) drive(make_opmode(W_RND, Z_P, Y_M, X_M), 2'd0, CIN_MULT, '0);
        report_test("mac_round");

        for (int i = 0; i < 48; i++) begin
            drive(make_opmode(W_ZERO, Z_C, Y_ZERO, X_AB), 2'(i),
                  (i % 3 == 0) ? CIN_PIN : (i % 3 == 1) ? CIN_P47 : CIN_NOT_P47,
                  C_W'(rand_bits(C_W)));
        end
        report_test("c_ab");

        // Random P loaded through W, then shifted or summed with all ones
        for (int i = 0; i < 40; i++) begin
            drive(make_opmode(W_C, Z_ZERO, Y_ZERO, X_ZERO), 2'd0, CIN_PIN,
                  C_W'(rand_bits(C_W)));
            drive(make_opmode(W_ZERO, (i % 2) ? Z_P_SHIFT : Z_P, Y_ONES, X_ZERO),
                  2'd0, CIN_PIN, '0);
        end
        report_test("shift_ones");

        // Earlier random tests also leave the pattern, so count afresh
        ovf_seen = 0;
        drive(make_opmode(W_C, Z_ZERO, Y_ZERO, X_ZERO), 2'd0, CIN_MULT, 48'h3FFF_FFF8_0000);
        for (n = 0; n < 40 && ovf_seen == 0; n++) begin
            drive(make_opmode(W_C, Z_P, Y_ZERO, X_ZERO), 2'd0, CIN_MULT, 48'h1_0000);
        end
        if (ovf_seen == 0) begin
            $display("Overflow never rose while accumulating from 00 into 01");
            tb_errors++;
        end
        unf_seen = 0;
        drive(make_opmode(W_C, Z_ZERO, Y_ZERO, X_ZERO), 2'd0, CIN_MULT, 48'hC000_0008_0000);
        for (n = 0; n < 40 && unf_seen == 0; n++) begin
            drive(make_opmode(W_C, Z_P, Y_ZERO, X_ZERO), 2'd3, CIN_MULT, 48'h1_0000);
        end
        if (unf_seen == 0) begin
            $display("Underflow never rose while counting down from 11 into 10");
            tb_errors++;
        end
        report_test("ovf_unf");

        $display("checks %0d, errors %0d", check_count, err_count + tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/dsp_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_assert (
    input logic w_CLK,
    input logic RSTALLCARRYIN,
    input logic pattern_detect,
    input logic patternb_detect,
    input logic overflow,
    input logic underflow
);

    // Leaving the pattern goes one way at a time
    a_not_both: assert property (@(posedge w_CLK) disable iff (RSTALLCARRYIN)
        !(overflow && underflow))
        else $error("overflow and underflow high together");

    // Overflow exactly when the zero pattern was left one edge ago
    a_ovf_no_flag: assert property (@(posedge w_CLK) disable iff (RSTALLCARRYIN)
        overflow == (!pattern_detect && !patternb_detect && $past(pattern_detect)))
        else $error("overflow does not follow the drop of pattern_detect");

    // Cleared P matches the zero pattern
    a_reset_vals: assert property (@(posedge w_CLK)
        RSTALLCARRYIN |=> (pattern_detect && !patternb_detect && !overflow && !underflow))
        else $error("flags wrong after reset");

endmodule

bind dsp_pattern_detect dsp_assert u_assert (.*);

`default_nettype wire

// File: test/dsp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_checker (
    input  logic                             w_CLK,
    input  logic                             RSTALLCARRYIN,
    input  logic [dsp_pkg::A_W-1:0]          a,
    input  logic [dsp_pkg::B_W-1:0]          b,
    input  logic [dsp_pkg::C_W-1:0]          c,
    input  logic [dsp_pkg::OPMODE_W-1:0]     opmode,
    input  logic [dsp_pkg::ALUMODE_W-1:0]    alumode,
    input  logic [dsp_pkg::CARRYINSEL_W-1:0] carryinsel,
    input  logic                             carryin,
    input  logic [dsp_pkg::C_W-1:0]          p,
    input  logic                             pattern_detect,
    input  logic                             patternb_detect,
    input  logic                             overflow,
    input  logic                             underflow,
    output int                               err_count,
    output int                               check_count
);
    import dsp_pkg::*;

    logic [47:0] ab_s, c_s, p_s, p_next;
    logic signed [44:0] m_s;
    logic [8:0] om_s;
    logic [1:0] am_s;
    logic [2:0] cs_s;
    logic ci_s, cm_s, pd_s, pdb_s, pd_old, pdb_old, armed;
    logic ovf_e, unf_e;

    // Signed 27x18 product of the A:B word
    function automatic logic signed [44:0] model_prod(input logic [47:0] ab);
        longint x;
        longint y;
        x = longint'($signed(ab[44:18]));
        y = longint'($signed(ab[17:0]));
        return 45'(x * y);
    endfunction

    function automatic logic [47:0] model_p(input logic [8:0] om, input logic [1:0] am,
                                            input logic [2:0] cs, input logic ci,
                                            input logic [47:0] cv, input logic [47:0] ab,
                                            input logic signed [44:0] m, input logic cm,
                                            input logic [47:0] pv);
        longint wv, xv, yv, zv, s, r;
        logic cin;
        wv = (om[8:7] == 2'd1) ? longint'(pv) : (om[8:7] == 2'd2) ? longint'(2**16) :
             (om[8:7] == 2'd3) ? longint'(cv) : 0;
        xv = (om[1:0] == 2'd1) ? longint'(m) : (om[1:0] == 2'd2) ? longint'(pv) :
             (om[1:0] == 2'd3) ? longint'(ab) : 0;
        yv = (om[3:2] == 2'd2) ? longint'(48'hFFFF_FFFF_FFFF) :
             (om[3:2] == 2'd3) ? longint'(cv) : 0;
        case (om[6:4])
            3'd2:    zv = longint'(pv);
            3'd3:    zv = longint'(cv);
            3'd6:    zv = longint'($signed(pv)) >>> 17;
            default: zv = 0;
        endcase
        case (cs)
            3'd0:    cin = ci;
            3'd5:    cin = !pv[47];
            3'd6:    cin = cm;
            3'd7:    cin = pv[47];
            default: cin = 1'b0;
        endcase
        s = wv + xv + yv + longint'(cin);
        case (am)
            2'd0:    r = zv + s;
            2'd1:    r = ~zv + s;
            2'd2:    r = ~(zv + s);
            default: r = zv - s;
        endcase
        return r[47:0];
    endfunction

    initial begin
        err_count   = 0;
        check_count = 0;
        armed       = 1'b0;
    end

    always @(posedge w_CLK) begin
        if (armed) begin
            ovf_e = !pd_s && !pdb_s && pd_old;
            unf_e = !pd_s && !pdb_s && pdb_old;
            check_count++;
            if (p !== p_s || pattern_detect !== pd_s || patternb_detect !== pdb_s ||
                overflow !== ovf_e || underflow !== unf_e) begin
                err_count++;
                $display("FAIL t=%0t p exp %h got %h, flags exp %b%b%b%b got %b%b%b%b",
                         $time, p_s, p, pd_s, pdb_s, ovf_e, unf_e,
                         pattern_detect, patternb_detect, overflow, underflow);
            end
        end
        if (RSTALLCARRYIN) begin
            {ab_s, c_s, p_s, m_s, om_s, am_s, cs_s, ci_s, cm_s} = '0;
            {pd_s, pdb_s, pd_old, pdb_old} = 4'b1010;
            armed = 1'b1;
        end else begin
            // Oldest stage first, so each one sees last cycle's values
            p_next  = model_p(om_s, am_s, cs_s, ci_s, c_s, ab_s, m_s, cm_s, p_s);
            pd_old  = pd_s;
            pdb_old = pdb_s;
            pd_s    = (p_next[47:46] == 2'b00);
            pdb_s   = (p_next[47:46] == 2'b11);
            p_s     = p_next;
            m_s     = model_prod(ab_s);
            cm_s    = (ab_s[44] == ab_s[17]);
            {om_s, am_s, cs_s, ci_s, c_s} = {opmode, alumode, carryinsel, carryin, c};
            ab_s    = {a, b};
        end
    end

endmodule

`default_nettype wire

// File: rtl/dsp_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_slice_top (
    input  logic                             w_CLK,
    input  logic                             RSTALLCARRYIN,
    input  logic [dsp_pkg::A_W-1:0]          a,
    input  logic [dsp_pkg::B_W-1:0]          b,
    input  logic [dsp_pkg::C_W-1:0]          c,
    input  logic [dsp_pkg::OPMODE_W-1:0]     opmode,
    input  logic [dsp_pkg::ALUMODE_W-1:0]    alumode,
    input  logic [dsp_pkg::CARRYINSEL_W-1:0] carryinsel,
    input  logic                             carryin,
    output logic [dsp_pkg::C_W-1:0]          p,
    output logic                             pattern_detect,
    output logic                             patternb_detect,
    output logic                             overflow,
    output logic                             underflow
);
    import dsp_pkg::*;

    ab_word_u                   ab_q;
    logic signed [PROD_W-1:0]   prod_q;
    logic                       cmult_q;
    logic [C_W-1:0]             c_q;
    logic [OPMODE_W-1:0]        opmode_q;
    logic [ALUMODE_W-1:0]       alumode_q;
    logic [CARRYINSEL_W-1:0]    carryinsel_q;
    logic                       carryin_q;
    logic [C_W-1:0]             alu_result;

    dsp_mult_stage u_mult (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .a             (a),
        .b             (b),
        .ab_q          (ab_q),
        .prod_q        (prod_q),
        .cmult_q       (cmult_q)
    );

    dsp_ctrl_regs u_ctrl (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .c             (c),
        .opmode        (opmode),
        .alumode       (alumode),
        .carryinsel    (carryinsel),
        .carryin       (carryin),
        .c_q           (c_q),
        .opmode_q      (opmode_q),
        .alumode_q     (alumode_q),
        .carryinsel_q  (carryinsel_q),
        .carryin_q     (carryin_q)
    );

    dsp_alu u_alu (
        .w_CLK         (w_CLK),
        .RSTALLCARRYIN (RSTALLCARRYIN),
        .ab_q          (ab_q),
        .prod_q        (prod_q),
        .cmult_q       (cmult_q),
        .c_q           (c_q),
        .opmode_q      (opmode_q),
        .alumode_q     (alumode_q),
        .carryinsel_q  (carryinsel_q),
        .carryin_q     (carryin_q),
        .p             (p),
        .alu_result    (alu_result)
    );

    // Flags register alongside P
    dsp_pattern_detect u_pdet (
        .w_CLK           (w_CLK),
        .RSTALLCARRYIN   (RSTALLCARRYIN),
        .alu_result      (alu_result),
        .pattern_detect  (pattern_detect),
        .patternb_detect (patternb_detect),
        .overflow        (overflow),
        .underflow       (underflow)
    );

endmodule

`default_nettype wire

// File: rtl/dsp_pattern_detect.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_pattern_detect (
    input  logic                    w_CLK,
    input  logic                    RSTALLCARRYIN,
    input  logic [dsp_pkg::C_W-1:0] alu_result,
    output logic                    pattern_detect,
    output logic                    patternb_detect,
    output logic                    overflow,
    output logic                    underflow
);
    import dsp_pkg::*;

    logic pdet_d;
    logic pdetb_d;
    logic pdet_prev;
    logic pdetb_prev;

    // Masked bits always count as a match
    assign pdet_d  = &(~(alu_result ^ PATTERN_VALUE) | MASK_VALUE);
    assign pdetb_d = &((alu_result ^ PATTERN_VALUE) | MASK_VALUE);

    // Flags load with P, and keep one older copy
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            // Cleared P matches the zero pattern
            pattern_detect  <= 1'b1;
            patternb_detect <= 1'b0;
            pdet_prev       <= 1'b1;
            pdetb_prev      <= 1'b0;
        end else begin
            pattern_detect  <= pdet_d;
            patternb_detect <= pdetb_d;
            pdet_prev       <= pattern_detect;
            pdetb_prev      <= patternb_detect;
        end
    end

    // Leaving the pattern upward or downward
    assign overflow  = ~pattern_detect & ~patternb_detect & pdet_prev;
    assign underflow = ~pattern_detect & ~patternb_detect & pdetb_prev;

endmodule

`default_nettype wire

// File: rtl/dsp_alu.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_alu (
    input  logic                              w_CLK,
    input  logic                              RSTALLCARRYIN,
    input  dsp_pkg::ab_word_u                 ab_q,
    input  logic signed [dsp_pkg::PROD_W-1:0] prod_q,
    input  logic                              cmult_q,
    input  logic [dsp_pkg::C_W-1:0]           c_q,
    input  logic [dsp_pkg::OPMODE_W-1:0]      opmode_q,
    input  logic [dsp_pkg::ALUMODE_W-1:0]     alumode_q,
    input  logic [dsp_pkg::CARRYINSEL_W-1:0]  carryinsel_q,
    input  logic                              carryin_q,
    output logic [dsp_pkg::C_W-1:0]           p,
    output logic [dsp_pkg::C_W-1:0]           alu_result
);
    import dsp_pkg::*;

    logic [1:0]     w_sel;
    logic [2:0]     z_sel;
    logic [1:0]     y_sel;
    logic [1:0]     x_sel;
    logic [C_W-1:0] prod_ext;
    logic [C_W-1:0] p_shift;
    logic [C_W-1:0] w_mux;
    logic [C_W-1:0] x_mux;
    logic [C_W-1:0] y_mux;
    logic [C_W-1:0] z_mux;
    logic           cin;
    logic [C_W-1:0] sum_s;

    // OPMODE fields
    assign w_sel = opmode_q[8:7];
    assign z_sel = opmode_q[6:4];
    assign y_sel = opmode_q[3:2];
    assign x_sel = opmode_q[1:0];

    // Product widened with its sign
    assign prod_ext = {{(C_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

    // P shifted right arithmetically by 17
    assign p_shift = {{SHIFT_W{p[C_W-1]}}, p[C_W-1:SHIFT_W]};

    always_comb begin
        case (w_sel)
            W_P:     w_mux = p;
            W_RND:   w_mux = RND_VALUE;
            W_C:     w_mux = c_q;
            default: w_mux = '0;
        endcase
    end

    // Whole product goes through X
    always_comb begin
        case (x_sel)
            X_M:     x_mux = prod_ext;
            X_P:     x_mux = p;
            X_AB:    x_mux = ab_q.word;
            default: x_mux = '0;
        endcase
    end

    // Y_M adds nothing since the product is not split
    always_comb begin
        case (y_sel)
            Y_ONES:  y_mux = '1;
            Y_C:     y_mux = c_q;
            default: y_mux = '0;
        endcase
    end

    // Codes without a source here read as zero
    always_comb begin
        case (z_sel)
            Z_P:       z_mux = p;
            Z_C:       z_mux = c_q;
            Z_P_SHIFT: z_mux = p_shift;
            default:   z_mux = '0;
        endcase
    end

    // Carry-in select
    always_comb begin
        case (carryinsel_q)
            CIN_PIN:     cin = carryin_q;
            CIN_NOT_P47: cin = ~p[C_W-1];
            CIN_MULT:    cin = cmult_q;
            CIN_P47:     cin = p[C_W-1];
            default:     cin = 1'b0;
        endcase
    end

    assign sum_s = w_mux + x_mux + y_mux + C_W'(cin);

    // All forms wrap modulo 2^48
    always_comb begin
        case (alumode_q)
            ALU_Z_PLUS:    alu_result = z_mux + sum_s;
            ALU_NOTZ_PLUS: alu_result = ~z_mux + sum_s;
            ALU_NOT_SUM:   alu_result = ~(z_mux + sum_s);
            default:       alu_result = z_mux - sum_s;
        endcase
    end

    // P register
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            p <= '0;
        end else begin
            p <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dsp_mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_mult_stage (
    input  logic                              w_CLK,
    input  logic                              RSTALLCARRYIN,
    input  logic [dsp_pkg::A_W-1:0]           a,
    input  logic [dsp_pkg::B_W-1:0]           b,
    output dsp_pkg::ab_word_u                 ab_q,
    output logic signed [dsp_pkg::PROD_W-1:0] prod_q,
    output logic                              cmult_q
);
    import dsp_pkg::*;

    logic signed [MULT_A_W-1:0] mult_a;
    logic signed [B_W-1:0]      mult_b;
    logic signed [PROD_W-1:0]   prod_d;
    logic                       cmult_d;

    // A:B input register
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            ab_q <= '0;
        end else begin
            ab_q.ops.a <= a;
            ab_q.ops.b <= b;
        end
    end

    // Multiplier sees only the low 27 bits of A
    assign mult_a = ab_q.ops.a[MULT_A_W-1:0];
    assign mult_b = ab_q.ops.b;

    // Both operands signed, extended to the full product width
    assign prod_d = mult_a * mult_b;

    // Rounding carry, set when the operand signs agree
    assign cmult_d = ~(mult_a[MULT_A_W-1] ^ mult_b[B_W-1]);

    // M register
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            prod_q  <= '0;
            cmult_q <= 1'b0;
        end else begin
            prod_q  <= prod_d;
            cmult_q <= cmult_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dsp_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_ctrl_regs (
    input  logic                             w_CLK,
    input  logic                             RSTALLCARRYIN,
    input  logic [dsp_pkg::C_W-1:0]          c,
    input  logic [dsp_pkg::OPMODE_W-1:0]     opmode,
    input  logic [dsp_pkg::ALUMODE_W-1:0]    alumode,
    input  logic [dsp_pkg::CARRYINSEL_W-1:0] carryinsel,
    input  logic                             carryin,
    output logic [dsp_pkg::C_W-1:0]          c_q,
    output logic [dsp_pkg::OPMODE_W-1:0]     opmode_q,
    output logic [dsp_pkg::ALUMODE_W-1:0]    alumode_q,
    output logic [dsp_pkg::CARRYINSEL_W-1:0] carryinsel_q,
    output logic                             carryin_q
);

    // C operand, one register deep
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            c_q <= '0;
        end else begin
            c_q <= c;
        end
    end

    // Control words share the same stage
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            opmode_q     <= '0;
            alumode_q    <= '0;
            carryinsel_q <= '0;
        end else begin
            opmode_q     <= opmode;
            alumode_q    <= alumode;
            carryinsel_q <= carryinsel;
        end
    end

    // Carry pin lines up with the controls
    always_ff @(posedge w_CLK) begin
        if (RSTALLCARRYIN) begin
            carryin_q <= 1'b0;
        end else begin
            carryin_q <= carryin;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    // Datapath widths
    localparam int A_W          = 30;
    localparam int B_W          = 18;
    localparam int MULT_A_W     = 27;
    localparam int C_W          = 48;
    localparam int PROD_W       = 45;
    localparam int OPMODE_W     = 9;
    localparam int ALUMODE_W    = 2;
    localparam int CARRYINSEL_W = 3;

    // W operand select, OPMODE[8:7]
    localparam logic [1:0] W_ZERO = 2'b00;
    localparam logic [1:0] W_P    = 2'b01;
    localparam logic [1:0] W_RND  = 2'b10;
    localparam logic [1:0] W_C    = 2'b11;

    // X operand select, OPMODE[1:0]
    localparam logic [1:0] X_ZERO = 2'b00;
    localparam logic [1:0] X_M    = 2'b01;
    localparam logic [1:0] X_P    = 2'b10;
    localparam logic [1:0] X_AB   = 2'b11;

    // Y operand select, OPMODE[3:2]
    localparam logic [1:0] Y_ZERO = 2'b00;
    localparam logic [1:0] Y_M    = 2'b01;
    localparam logic [1:0] Y_ONES = 2'b10;
    localparam logic [1:0] Y_C    = 2'b11;

    // Z operand select, OPMODE[6:4]
    localparam logic [2:0] Z_ZERO    = 3'b000;
    localparam logic [2:0] Z_P       = 3'b010;
    localparam logic [2:0] Z_C       = 3'b011;
    localparam logic [2:0] Z_P_SHIFT = 3'b110;

    // Carry-in sources
    localparam logic [2:0] CIN_PIN     = 3'b000;
    localparam logic [2:0] CIN_NOT_P47 = 3'b101;
    localparam logic [2:0] CIN_MULT    = 3'b110;
    localparam logic [2:0] CIN_P47     = 3'b111;

    // Arithmetic forms of the adder
    localparam logic [1:0] ALU_Z_PLUS    = 2'b00;
    localparam logic [1:0] ALU_NOTZ_PLUS = 2'b01;
    localparam logic [1:0] ALU_NOT_SUM   = 2'b10;
    localparam logic [1:0] ALU_Z_MINUS   = 2'b11;

    // Fixed shift, rounding and detector constants
    localparam int               SHIFT_W       = 17;
    localparam logic [C_W-1:0]   RND_VALUE     = 48'h0000_0001_0000;
    localparam logic [C_W-1:0]   PATTERN_VALUE = 48'h0000_0000_0000;
    // Only P[47:46] take part in the compare
    localparam logic [C_W-1:0]   MASK_VALUE    = 48'h3FFF_FFFF_FFFF;

    // Registered A:B word, seen as multiplier operands or as one X operand
    typedef union packed {
        struct packed {
            logic [A_W-1:0] a;
            logic [B_W-1:0] b;
        } ops;
        logic [A_W+B_W-1:0] word;
    } ab_word_u;

endpackage

`default_nettype wire
